// ==== mdv_unit.f ====
design/mdv_pkg.sv
design/mdv_op_decode.sv
design/mdv_ctrl.sv
design/mdv_booth_mul.sv
design/mdv_nrdiv.sv
design/mdv_shared_dp.sv
design/mdv_unit.sv
verification/mdv_unit_chk.sv
verification/mdv_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the mdv_unit testbench
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module mdv_unit_tb -f mdv_unit.f --Mdir $(BUILD) -o mdv_unit_sim
	./$(BUILD)/mdv_unit_sim | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/mdv_unit_tb.sv ====
module mdv_unit_tb
  import mdv_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 4;
  // Longest operation is 36 cycles, a few more for the sink to accept
  localparam int MAX_LAT    = 40;
  localparam int N_CORNER   = 8 * 5 * 5;
  localparam int N_RAND_MUL = 60;
  localparam int N_RAND_DIV = 100;
  localparam int N_BP       = 60;
  localparam int N_B2B      = 40;
  localparam int N_OPS      = N_CORNER + N_RAND_MUL + N_RAND_DIV + N_BP + N_B2B;
  localparam int WATCHDOG_NS = N_OPS * MAX_LAT * CLK_PERIOD + 2000;
  localparam xlen_t MOST_NEG = 32'h8000_0000;

  logic     clk;
  logic     i_rst;
  logic     i_valid;
  mdv_req_t i_req;
  logic     o_ready;
  logic     o_valid;
  xlen_t    o_data;
  logic     i_ready;

  xlen_t    rng_state;
  bit       bp_en;
  int       n_issued;
  int       n_checked;
  xlen_t    corners [5];
  // Expected results in issue order
  xlen_t    exp_q[$];
  string    desc_q[$];

  mdv_unit mdv_unit_i (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_req   (i_req),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_data  (o_data),
    .i_ready (i_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic finish_failed();
    $display("test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_error(input string why);
    $display("ERROR at %0d ns: %s", $time, why);
    finish_failed();
  endtask

  task automatic check_val(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
      finish_failed();
    end
  endtask

  ////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////

  // 32-bit xorshift
  function automatic xlen_t next_rand();
    xlen_t x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // RV32M results on 64-bit arithmetic
  function automatic xlen_t ref_mdv(input mdv_op_e op, input xlen_t a, input xlen_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        prod;
    logic               ovf;
    xlen_t              res;
    sa   = {{32{a[31]}}, a};
    sb   = {{32{b[31]}}, b};
    ua   = {32'd0, a};
    ub   = {32'd0, b};
    ovf  = (a == MOST_NEG) && (b == '1);
    prod = '0;
    case (op)
      OP_MUL: begin
        prod = sa * sb;
        res  = prod[31:0];
      end
      OP_MULH: begin
        prod = sa * sb;
        res  = prod[63:32];
      end
      OP_MULHSU: begin
        // Sign-extended rs1 times zero-extended rs2, modulo 2^64
        prod = sa * ub;
        res  = prod[63:32];
      end
      OP_MULHU: begin
        prod = ua * ub;
        res  = prod[63:32];
      end
      OP_DIV: begin
        if (b == '0) begin
          res = '1;
        end else if (ovf) begin
          res = MOST_NEG;
        end else begin
          prod = sa / sb;
          res  = prod[31:0];
        end
      end
      OP_DIVU: begin
        res = (b == '0) ? '1 : a / b;
      end
      OP_REM: begin
        if (b == '0) begin
          res = a;
        end else if (ovf) begin
          res = '0;
        end else begin
          // Remainder takes the dividend sign
          prod = sa % sb;
          res  = prod[31:0];
        end
      end
      default: begin
        res = (b == '0) ? a : a % b;
      end
    endcase
    return res;
  endfunction

  // Cycle of the first o_valid, 34 stands for 34 or 36 on a divide
  function automatic int first_valid_cycle(input mdv_op_e op, input xlen_t a, input xlen_t b);
    bit is_div;
    bit special;
    is_div  = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    special = is_div && ((b == '0)
            || ((op inside {OP_DIV, OP_REM}) && (a == MOST_NEG) && (b == '1)));
    if (special)
      return 1;
    else if (!is_div)
      return 17;
    else
      return 34;
  endfunction

  // Small divisors of either sign give long quotients
  function automatic xlen_t rand_divisor();
    xlen_t r;
    xlen_t d;
    r = next_rand();
    d = next_rand() >> r[4:0];
    if (r[5])
      d = -d;
    return d;
  endfunction

  function automatic logic pick_ready();
    xlen_t r;
    if (!bp_en)
      return 1'b1;
    r = next_rand();
    return r[0];
  endfunction

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  // Entered and left on a falling edge
  task automatic idle(input int n);
    i_valid = 1'b0;
    i_req   = '0;
    i_ready = 1'b1;
    repeat (n) @(negedge clk);
  endtask

  // One request held until its result is taken
  task automatic run_op(input mdv_op_e op, input xlen_t a, input xlen_t b);
    int    cyc;
    int    lat_exp;
    bit    seen;
    bit    taken;
    xlen_t held;
    i_valid   = 1'b1;
    i_req.op  = op;
    i_req.rs1 = a;
    i_req.rs2 = b;
    i_ready   = pick_ready();
    exp_q.push_back(ref_mdv(op, a, b));
    desc_q.push_back($sformatf("o_data (%s %h %h)", op.name(), a, b));
    n_issued++;
    cyc   = 1;
    seen  = 1'b0;
    taken = 1'b0;
    held  = '0;
    while (!taken) begin
      @(posedge clk);
      if (o_valid) begin
        if (!seen) begin
          lat_exp = first_valid_cycle(op, a, b);
          // Correction adds two cycles
          if (lat_exp == 34 && cyc == 36)
            lat_exp = 36;
          check_val("o_valid latency", xlen_t'(cyc), xlen_t'(lat_exp));
          held = o_data;
          seen = 1'b1;
        end else begin
          check_val("o_data while held", o_data, held);
        end
        // Request accepted exactly when the result is taken
        check_val("o_ready", xlen_t'(o_ready), xlen_t'(i_ready));
        taken = i_ready;
      end else if (seen) begin
        report_error("o_valid dropped before the result was taken");
      end else if (cyc >= MAX_LAT) begin
        report_error($sformatf("no result for %s after %0d cycles", op.name(), cyc));
      end else begin
        check_val("o_ready", xlen_t'(o_ready), '0);
      end
      @(negedge clk);
      cyc++;
      if (!taken)
        i_ready = pick_ready();
    end
  endtask

  ////////////////////////////////////////
  // Result compare
  ////////////////////////////////////////

  always @(posedge clk) begin : compare_results
    xlen_t exp_val;
    string what;
    if (i_rst && o_valid)
      report_error("o_valid high during reset");
    if (o_valid && !i_valid)
      report_error("o_valid high without a pending request");
    if (!i_rst && o_valid && i_ready) begin
      if (exp_q.size() == 0) begin
        report_error("result taken with no request outstanding");
      end else begin
        exp_val = exp_q.pop_front();
        what    = desc_q.pop_front();
        check_val(what, o_data, exp_val);
        n_checked++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    report_error("watchdog expired, the run took far longer than the tests need");
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : main
    mdv_op_e op;
    xlen_t   a;
    xlen_t   b;
    xlen_t   r;
    i_rst     = 1'b1;
    i_valid   = 1'b0;
    i_req     = '0;
    i_ready   = 1'b1;
    bp_en     = 1'b0;
    rng_state = 32'd53;
    n_issued  = 0;
    n_checked = 0;
    corners   = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, MOST_NEG, 32'h7FFF_FFFF};
    repeat (4) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;

    // Idle unit stays quiet
    repeat (8) begin
      @(posedge clk);
      check_val("o_valid", xlen_t'(o_valid), '0);
      check_val("o_ready", xlen_t'(o_ready), '0);
    end
    @(negedge clk);

    // Every operation on every corner pair, special cases included
    for (int o = 0; o < 8; o++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          run_op(mdv_op_e'(o[2:0]), corners[i], corners[j]);
          idle(1);
        end
      end
    end

    // Random multiplies
    for (int k = 0; k < N_RAND_MUL; k++) begin
      r = next_rand();
      a = next_rand();
      b = next_rand();
      run_op(mdv_op_e'({1'b0, r[1:0]}), a, b);
      idle(1);
    end

    // Random divides and remainders, mixed signs
    for (int k = 0; k < N_RAND_DIV; k++) begin
      r = next_rand();
      a = next_rand();
      b = rand_divisor();
      run_op(mdv_op_e'({1'b1, r[1:0]}), a, b);
      idle(1);
    end

    // Sink stalls at random
    bp_en = 1'b1;
    for (int k = 0; k < N_BP; k++) begin
      r  = next_rand();
      op = mdv_op_e'(r[2:0]);
      a  = next_rand();
      b  = r[3] ? rand_divisor() : next_rand();
      run_op(op, a, b);
    end
    bp_en = 1'b0;
    idle(2);

    // Requests back to back, each right after the previous handshake
    for (int k = 0; k < N_B2B; k++) begin
      r  = next_rand();
      op = mdv_op_e'(r[2:0]);
      a  = next_rand();
      b  = rand_divisor();
      run_op(op, a, b);
    end
    idle(4);

    if (n_checked != n_issued) begin
      report_error($sformatf("%0d requests issued, %0d results checked", n_issued, n_checked));
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// ==== verification/mdv_unit_chk.sv ====
module mdv_unit_chk
  import mdv_pkg::*;
(
  input logic  clk,
  input logic  i_rst,
  input logic  i_valid,
  input logic  i_ready,
  input logic  o_valid,
  input xlen_t o_data
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // Handshake rules
  ////////////////////////////////////////

  // Result only offered against a pending request
  a_valid_needs_req : assert property (
    @(posedge clk) disable iff (i_rst) o_valid |-> i_valid
  ) else $error("o_valid high while i_valid is low");

  // Result waiting on the sink must not move
  a_data_held : assert property (
    @(posedge clk) disable iff (i_rst) (o_valid && !i_ready) |=> $stable(o_data)
  ) else $error("o_data changed before the result was taken");

  // Nothing comes out under reset
  a_quiet_in_reset : assert property (
    @(posedge clk) i_rst |-> !o_valid
  ) else $error("o_valid high during reset");

endmodule

bind mdv_unit mdv_unit_chk mdv_unit_chk_i (
  .clk     (clk),
  .i_rst   (i_rst),
  .i_valid (i_valid),
  .i_ready (i_ready),
  .o_valid (o_valid),
  .o_data  (o_data)
);

// ==== design/mdv_unit.sv ====
module mdv_unit
  import mdv_pkg::*;
(
  input  logic     clk,
  input  logic     i_rst,
  // Request side
  input  logic     i_valid,
  input  mdv_req_t i_req,
  output logic     o_ready,
  // Result side
  output logic     o_valid,
  output xlen_t    o_data,
  input  logic     i_ready
);

  mdv_dec_t     dec;
  mdv_phase_t   phase;
  logic         done;
  logic         need_corr;
  xlen_t        special_data;
  xlen_t        mul_data;
  xlen_t        div_data;
  adder_t       sum;
  opnd_t        buf0;
  opnd_t        buf1;
  mdv_add_req_t mul_add;
  mdv_add_req_t div_add;
  mdv_buf_wr_t  mul_hi_wr;
  mdv_buf_wr_t  mul_lo_wr;
  mdv_buf_wr_t  div_remd_wr;
  mdv_buf_wr_t  div_quot_wr;

  mdv_op_decode op_decode_i (
    .i_req          (i_req),
    .o_dec          (dec),
    .o_special_data (special_data)
  );

  mdv_ctrl ctrl_i (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_ready     (i_ready),
    .i_dec       (dec),
    .i_need_corr (need_corr),
    .o_phase     (phase),
    .o_done      (done)
  );

  mdv_booth_mul booth_mul_i (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_req    (i_req),
    .i_dec    (dec),
    .i_phase  (phase),
    .i_sum    (sum),
    .i_buf_hi (buf0),
    .i_buf_lo (buf1),
    .o_add    (mul_add),
    .o_hi_wr  (mul_hi_wr),
    .o_lo_wr  (mul_lo_wr),
    .o_data   (mul_data)
  );

  mdv_nrdiv nrdiv_i (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_req       (i_req),
    .i_dec       (dec),
    .i_phase     (phase),
    .i_sum       (sum),
    .i_remd      (buf0),
    .i_quot      (buf1),
    .o_add       (div_add),
    .o_remd_wr   (div_remd_wr),
    .o_quot_wr   (div_quot_wr),
    .o_need_corr (need_corr),
    .o_data      (div_data)
  );

  ////////////////////////////////////////
  // Shared adder and buffers
  ////////////////////////////////////////

  // Active datapath owns the adder and both buffers
  mdv_shared_dp shared_dp_i (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_add     (dec.is_mul ? mul_add : div_add),
    .i_buf0_wr (dec.is_mul ? mul_hi_wr : div_remd_wr),
    .i_buf1_wr (dec.is_mul ? mul_lo_wr : div_quot_wr),
    .o_sum     (sum),
    .o_buf0    (buf0),
    .o_buf1    (buf1)
  );

  // Write-back select
  always_comb begin
    if (dec.special)
      o_data = special_data;
    else if (dec.is_mul)
      o_data = mul_data;
    else
      o_data = div_data;
  end

  // Request is held until the result is taken
  // both handshakes land in one cycle
  assign o_valid = done & i_valid;
  assign o_ready = done & i_ready;

endmodule

// ==== design/mdv_shared_dp.sv ====
module mdv_shared_dp
  import mdv_pkg::*;
(
  input  logic         clk,
  input  logic         i_rst,
  input  mdv_add_req_t i_add,
  input  mdv_buf_wr_t  i_buf0_wr,
  input  mdv_buf_wr_t  i_buf1_wr,
  output adder_t       o_sum,
  output opnd_t        o_buf0,
  output opnd_t        o_buf1
);

  adder_t op2_inv;

  // One carry chain for add and subtract
  // subtract inverts op2 and feeds a carry in
  assign op2_inv = i_add.op2 ^ {ADDER_W{i_add.sub}};
  assign o_sum   = i_add.op1 + op2_inv + adder_t'(i_add.sub);

  // Buffer 0 holds product high or remainder
  // buffer 1 holds product low or quotient
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_buf0 <= '0;
      o_buf1 <= '0;
    end else begin
      if (i_buf0_wr.en)
        o_buf0 <= i_buf0_wr.nxt;
      if (i_buf1_wr.en)
        o_buf1 <= i_buf1_wr.nxt;
    end
  end

endmodule

// ==== design/mdv_nrdiv.sv ====
module mdv_nrdiv
  import mdv_pkg::*;
(
  input  logic         clk,
  input  logic         i_rst,
  input  mdv_req_t     i_req,
  input  mdv_dec_t     i_dec,
  input  mdv_phase_t   i_phase,
  input  adder_t       i_sum,
  input  opnd_t        i_remd,
  input  opnd_t        i_quot,
  output mdv_add_req_t o_add,
  output mdv_buf_wr_t  o_remd_wr,
  output mdv_buf_wr_t  o_quot_wr,
  output logic         o_need_corr,
  output xlen_t        o_data
);

  logic            rs1_sign;
  logic            rs2_sign;
  logic [OPND_W:0] divisor;
  logic [OPND_W:0] step_res;
  logic            quot_0th;
  logic            prev_quot;
  logic            cur_quot;
  opnd_t           quot_src;
  logic            remd_ext_r;
  logic            inc_dec;
  logic            remd_is_0;
  logic            remd_is_neg_divs;
  logic            remd_is_divs;
  opnd_t           remd_out;

  assign rs1_sign = i_dec.rs1_signed & i_req.rs1[XLEN-1];
  assign rs2_sign = i_dec.rs2_signed & i_req.rs2[XLEN-1];

  // Divisor with two sign bits
  assign divisor = {rs2_sign, rs2_sign, i_req.rs2};

  // Only the low 34 bits of the shared sum matter here
  assign step_res = i_sum[OPND_W:0];

  ////////////////////////////////////////
  // Non-restoring steps
  ////////////////////////////////////////

  // First quotient digit is -1 when the signs differ
  assign quot_0th = !(rs1_sign ^ rs2_sign);

  // Dividend low bits enter on the zeroth cycle
  // quotient bits then shift in behind them
  assign quot_src  = i_phase.zeroth ? {i_req.rs1, quot_0th} : i_quot;
  assign prev_quot = i_phase.zeroth ? quot_0th : i_quot[0];

  // New digit from the sign of the partial remainder
  assign cur_quot = !(step_res[OPND_W] ^ divisor[OPND_W]);

  // Subtract after a 1 digit, add after a -1 digit
  // same adder serves the check and the two corrections
  always_comb begin
    o_add.op1 = {1'b0, i_remd[OPND_W-1], i_remd};
    o_add.op2 = {1'b0, divisor};
    o_add.sub = 1'b0;
    if (i_phase.zeroth || i_phase.exec) begin
      o_add.op1 = {1'b0, (i_phase.zeroth ? {(OPND_W+1){rs1_sign}} : {remd_ext_r, i_remd})};
      o_add.sub = prev_quot;
    end else if (i_phase.quot_corr) begin
      o_add.op1 = {1'b0, i_quot[OPND_W-1], i_quot};
      o_add.op2 = adder_t'(1);
      o_add.sub = inc_dec;
    end else if (i_phase.corr) begin
      o_add.sub = !inc_dec;
    end
  end

  // Remainder buffer holds 33 bits
  // bit 33 of the step result waits here for the next step
  always_ff @(posedge clk) begin
    if (i_rst)
      remd_ext_r <= 1'b0;
    else if (o_remd_wr.en)
      remd_ext_r <= step_res[OPND_W-1];
  end

  assign o_remd_wr.en = !i_dec.is_mul
                      & (i_phase.step_ena | i_phase.exit_exec | i_phase.remd_corr_ena);
  assign o_quot_wr.en = !i_dec.is_mul
                      & (i_phase.step_ena | i_phase.exit_exec | i_phase.quot_corr_ena);

  always_comb begin
    if (i_phase.corr) begin
      o_remd_wr.nxt = i_sum[OPND_W-1:0];
      o_quot_wr.nxt = i_sum[OPND_W-1:0];
    end else if (i_phase.exec_last) begin
      // Final remainder stays unshifted, last quotient digit forced to 1
      o_remd_wr.nxt = step_res[OPND_W-1:0];
      o_quot_wr.nxt = {i_quot[XLEN-1:0], 1'b1};
    end else begin
      // Remainder and quotient shift left as one 66-bit value
      o_remd_wr.nxt = {step_res[XLEN-1:0], quot_src[OPND_W-1]};
      o_quot_wr.nxt = {quot_src[XLEN-1:0], cur_quot};
    end
  end

  ////////////////////////////////////////
  // Remainder check and correction
  ////////////////////////////////////////

  assign remd_is_0        = (i_remd == '0);
  // Check cycle adds the divisor, zero sum means remainder is -divisor
  assign remd_is_neg_divs = (step_res == '0);
  assign remd_is_divs     = (i_remd == divisor[OPND_W-1:0]);

  // Remainder must carry the dividend sign and stay inside the divisor
  assign o_need_corr = i_phase.chck & !i_dec.is_mul
                     & (((i_remd[OPND_W-1] ^ rs1_sign) & !remd_is_0)
                        | remd_is_neg_divs
                        | remd_is_divs);

  // Remainder and divisor signs differ
  // quotient goes down by one and the remainder up by the divisor
  assign inc_dec = i_remd[OPND_W-1] ^ divisor[OPND_W];

  // Corrected remainder leaves straight from the adder
  assign remd_out = i_phase.corr ? i_sum[OPND_W-1:0] : i_remd;

  assign o_data = i_dec.want_quot ? i_quot[XLEN-1:0] : remd_out[XLEN-1:0];

endmodule

// ==== design/mdv_booth_mul.sv ====
module mdv_booth_mul
  import mdv_pkg::*;
(
  input  logic         clk,
  input  logic         i_rst,
  input  mdv_req_t     i_req,
  input  mdv_dec_t     i_dec,
  input  mdv_phase_t   i_phase,
  input  adder_t       i_sum,
  input  opnd_t        i_buf_hi,
  input  opnd_t        i_buf_lo,
  output mdv_add_req_t o_add,
  output mdv_buf_wr_t  o_hi_wr,
  output mdv_buf_wr_t  o_lo_wr,
  output xlen_t        o_data
);

  logic       rs1_sign;
  logic       rs2_sign;
  logic [2:0] booth_code;
  logic       sel_zero;
  logic       sel_two;
  adder_t     rs2_x1;
  adder_t     rs2_x2;
  logic       sft1_r;
  logic       sft1_nxt;
  logic       wr_en;

  // Operand sign bits for the 33-bit extended operands
  assign rs1_sign = i_dec.rs1_signed & i_req.rs1[XLEN-1];
  assign rs2_sign = i_dec.rs2_signed & i_req.rs2[XLEN-1];

  ////////////////////////////////////////
  // Radix-4 recoding
  ////////////////////////////////////////

  // Bits 2i+1, 2i and 2i-1 of the multiplier
  // low buffer shifts rs1 down two bits per step
  // last digit takes the sign as its top bit
  always_comb begin
    if (i_phase.zeroth)
      booth_code = {i_req.rs1[1:0], 1'b0};
    else if (i_phase.exec_last)
      booth_code = {rs1_sign, i_buf_lo[0], sft1_r};
    else
      booth_code = {i_buf_lo[1:0], sft1_r};
  end

  // 000 and 111 add nothing
  // 011 and 100 take twice rs2, the rest take rs2 once
  // Top bit set means subtract
  assign sel_zero = (booth_code == 3'b000) | (booth_code == 3'b111);
  assign sel_two  = (booth_code == 3'b011) | (booth_code == 3'b100);

  assign rs2_x1 = {{3{rs2_sign}}, i_req.rs2};
  assign rs2_x2 = {{2{rs2_sign}}, i_req.rs2, 1'b0};

  // Partial product high part plus the selected multiple
  assign o_add.op1 = i_phase.zeroth ? '0 : {{2{i_buf_hi[OPND_W-1]}}, i_buf_hi};
  assign o_add.op2 = sel_zero ? '0 : (sel_two ? rs2_x2 : rs2_x1);
  assign o_add.sub = booth_code[2];

  // Shift right by two per step
  // the two bits dropped from the sum move into the low buffer
  assign wr_en = i_dec.is_mul & i_phase.step_ena;

  assign o_hi_wr.en  = wr_en;
  assign o_hi_wr.nxt = i_sum[ADDER_W-1:2];
  assign o_lo_wr.en  = wr_en;
  assign o_lo_wr.nxt = {i_sum[1:0],
                        (i_phase.zeroth ? {rs1_sign, i_req.rs1[XLEN-1:2]}
                                        : i_buf_lo[OPND_W-1:2])};

  // Bit 2i-1 of the next digit
  assign sft1_nxt = i_phase.zeroth ? i_req.rs1[1] : i_buf_lo[1];

  always_ff @(posedge clk) begin
    if (i_rst)
      sft1_r <= 1'b0;
    else if (wr_en)
      sft1_r <= sft1_nxt;
  end

  // Low word is complete in the buffer
  // high word comes out of the last adder step
  assign o_data = i_dec.mul_lo ? i_buf_lo[OPND_W-1:1] : i_sum[XLEN-1:0];

endmodule

// ==== design/mdv_ctrl.sv ====
module mdv_ctrl
  import mdv_pkg::*;
(
  input  logic       clk,
  input  logic       i_rst,
  input  logic       i_valid,
  input  logic       i_ready,
  input  mdv_dec_t   i_dec,
  input  logic       i_need_corr,
  output mdv_phase_t o_phase,
  output logic       o_done
);

  mdv_state_e state_r;
  mdv_state_e state_nxt;
  cnt_t       cnt_r;

  logic st_zero;
  logic st_exec;
  logic st_chck;
  logic st_qcorr;
  logic st_rcorr;
  logic exec_last;
  logic hsk;
  logic cnt_set;
  logic cnt_inc;

  assign st_zero  = (state_r == ZERO);
  assign st_exec  = (state_r == EXEC);
  assign st_chck  = (state_r == REMD_CHCK);
  assign st_qcorr = (state_r == QUOT_CORR);
  assign st_rcorr = (state_r == REMD_CORR);

  // Last execute cycle depends on the operation class
  assign exec_last = st_exec & (cnt_r == (i_dec.is_mul ? MUL_STEPS : DIV_STEPS));

  // Result complete
  // special cases answer straight out of ZERO
  assign o_done = (st_zero & i_dec.special)
                | (exec_last & i_dec.is_mul)
                | (st_chck & !i_need_corr)
                | st_rcorr;

  // Request and result complete together
  assign hsk = o_done & i_valid & i_ready;

  // Counter starts at 1, the zeroth cycle is step 0
  assign cnt_set = st_zero & i_valid & !i_dec.special;
  assign cnt_inc = st_exec & !exec_last;

  ////////////////////////////////////////
  // State sequencing
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ZERO: begin
        if (cnt_set)
          state_nxt = EXEC;
      end
      EXEC: begin
        if (exec_last) begin
          // Divide always goes on to the remainder check
          if (!i_dec.is_mul)
            state_nxt = REMD_CHCK;
          else if (hsk)
            state_nxt = ZERO;
        end
      end
      REMD_CHCK: begin
        if (i_need_corr)
          state_nxt = QUOT_CORR;
        else if (hsk)
          state_nxt = ZERO;
      end
      QUOT_CORR: begin
        state_nxt = REMD_CORR;
      end
      REMD_CORR: begin
        if (hsk)
          state_nxt = ZERO;
      end
      default: begin
        state_nxt = ZERO;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_r <= ZERO;
      cnt_r   <= '0;
    end else begin
      state_r <= state_nxt;
      if (cnt_set)
        cnt_r <= cnt_t'(1);
      else if (cnt_inc)
        cnt_r <= cnt_r + 1'b1;
    end
  end

  // Phase flags to the datapaths
  assign o_phase.zeroth    = st_zero;
  assign o_phase.exec      = st_exec;
  assign o_phase.exec_last = exec_last;
  assign o_phase.chck      = st_chck;
  assign o_phase.corr      = st_qcorr | st_rcorr;
  assign o_phase.quot_corr = st_qcorr;

  assign o_phase.step_ena      = cnt_set | cnt_inc;
  // Leaving EXEC, a multiply waits for the result to be taken
  assign o_phase.exit_exec     = exec_last & (!i_dec.is_mul | hsk);
  assign o_phase.quot_corr_ena = st_qcorr;
  assign o_phase.remd_corr_ena = st_rcorr & hsk;

endmodule

// ==== design/mdv_op_decode.sv ====
module mdv_op_decode
  import mdv_pkg::*;
(
  input  mdv_req_t i_req,
  output mdv_dec_t o_dec,
  output xlen_t    o_special_data
);

  logic is_mul;
  logic want_quot;
  logic div_by_0;
  logic div_ovf;

  // Operation class
  assign is_mul    = i_req.op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  assign want_quot = i_req.op inside {OP_DIV, OP_DIVU};

  assign o_dec.is_mul    = is_mul;
  assign o_dec.mul_lo    = (i_req.op == OP_MUL);
  assign o_dec.want_quot = want_quot;

  // Operand signedness
  // MUL gives the same low word either way, so it runs signed x signed
  assign o_dec.rs1_signed = !(i_req.op inside {OP_MULHU, OP_DIVU, OP_REMU});
  assign o_dec.rs2_signed = i_req.op inside {OP_MUL, OP_MULH, OP_DIV, OP_REM};

  ////////////////////////////////////////
  // Divide special cases
  ////////////////////////////////////////

  // Divisor of zero
  assign div_by_0 = (i_req.rs2 == '0);

  // Most negative dividend over minus one, signed forms only
  assign div_ovf = (i_req.op inside {OP_DIV, OP_REM})
                 & (&i_req.rs2)
                 & (i_req.rs1 == {1'b1, {(XLEN-1){1'b0}}});

  assign o_dec.special = !is_mul & (div_by_0 | div_ovf);

  // Fixed results, divide by zero wins when both hold
  always_comb begin
    if (div_by_0) begin
      // All ones quotient, dividend as remainder
      o_special_data = want_quot ? '1 : i_req.rs1;
    end else begin
      // Most negative quotient, zero remainder
      o_special_data = want_quot ? {1'b1, {(XLEN-1){1'b0}}} : '0;
    end
  end

endmodule

// ==== design/mdv_pkg.sv ====
package mdv_pkg;

  // Register width and the widths derived from it
  localparam int XLEN    = 32;
  // One sign bit above a register value
  localparam int OPND_W  = XLEN + 1;
  // Room for the doubled Booth multiple and its sign
  localparam int ADDER_W = XLEN + 3;
  localparam int CNT_W   = 6;

  typedef logic [XLEN-1:0]    xlen_t;
  typedef logic [OPND_W-1:0]  opnd_t;
  typedef logic [ADDER_W-1:0] adder_t;
  typedef logic [CNT_W-1:0]   cnt_t;

  // Execute cycles after the zeroth cycle
  localparam cnt_t MUL_STEPS = cnt_t'(16);
  localparam cnt_t DIV_STEPS = cnt_t'(32);

  // RV32M operations, multiplies in the lower half of the encoding
  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } mdv_op_e;

  typedef enum logic [2:0] {
    ZERO      = 3'd0,
    EXEC      = 3'd1,
    REMD_CHCK = 3'd2,
    QUOT_CORR = 3'd3,
    REMD_CORR = 3'd4
  } mdv_state_e;

  typedef struct packed {
    mdv_op_e op;
    xlen_t   rs1;
    xlen_t   rs2;
  } mdv_req_t;

  typedef struct packed {
    logic is_mul;
    logic mul_lo;
    logic rs1_signed;
    logic rs2_signed;
    logic want_quot;
    logic special;
  } mdv_dec_t;

  // Request to the shared adder, op1 minus op2 when sub is set
  typedef struct packed {
    adder_t op1;
    adder_t op2;
    logic   sub;
  } mdv_add_req_t;

  typedef struct packed {
    logic  en;
    opnd_t nxt;
  } mdv_buf_wr_t;

  typedef struct packed {
    // Current cycle of the operation
    logic zeroth;
    logic exec;
    logic exec_last;
    logic chck;
    logic corr;
    logic quot_corr;
    // Buffer update strobes
    logic step_ena;
    logic exit_exec;
    logic quot_corr_ena;
    logic remd_corr_ena;
  } mdv_phase_t;

endpackage
